//--- common/lsu_pkg.sv
// load/store operation codes, ram sizing constants, width types and lane helpers
package lsu_pkg;

  // ram geometry, one 64-bit word per entry
  localparam int MEM_WORDS   = 256;
  localparam int WORD_IDX_W  = $clog2(MEM_WORDS);
  localparam int DWORD_BYTES = 8;
  // byte offset width inside a word
  localparam int OFS_W       = $clog2(DWORD_BYTES);

  typedef logic [63:0]              dword_t;
  typedef logic [63:0]              addr_t;
  typedef logic [DWORD_BYTES-1:0]   byte_mask_t;
  typedef logic [OFS_W-1:0]         lane_ofs_t;
  typedef logic [WORD_IDX_W-1:0]    word_idx_t;

  // bit 0 clear means sign extension on loads
  // bits 2:1 encode the access size as log2 of the byte count
  typedef enum logic [2:0] {
    OP_BYTE_S = 3'b000,
    OP_BYTE_U = 3'b001,
    OP_HALF_S = 3'b010,
    OP_HALF_U = 3'b011,
    OP_WORD_S = 3'b100,
    OP_WORD_U = 3'b101,
    OP_DOUBLE = 3'b110,
    OP_NONE   = 3'b111
  } mem_op_e;

  // log2 of the access size in bytes
  // code 111 reports a double, it never reaches the ram anyway
  function automatic logic [1:0] op_size_log2(mem_op_e op);
    return op[2:1];
  endfunction

  // clear the offset bits below the access size
  function automatic lane_ofs_t align_ofs(lane_ofs_t ofs, logic [1:0] size_log2);
    lane_ofs_t keep;
    keep = lane_ofs_t'(3'b111 << size_log2);
    return ofs & keep;
  endfunction

endpackage

//--- common/mem_bus_if.sv
// memory bus interface between store path, data ram and load path, with modports
`timescale 1ns/1ps

interface mem_bus_if;
  import lsu_pkg::*;

  // ram word address, shared by reads and writes
  word_idx_t  ram_idx;
  // write data already moved into its byte lanes
  dword_t     ram_wdata;
  // one bit per byte lane to be written
  byte_mask_t ram_wmask;
  // single-cycle strobes, never high together
  logic       ram_wen;
  logic       ram_ren;
  // registered read word, valid the cycle after ram_ren
  dword_t     ram_rdata;

  // request side, driven combinationally from the core request
  modport store (
    output ram_idx,
    output ram_wdata,
    output ram_wmask,
    output ram_wen,
    output ram_ren
  );

  // storage array side
  modport ram (
    input  ram_idx,
    input  ram_wdata,
    input  ram_wmask,
    input  ram_wen,
    input  ram_ren,
    output ram_rdata
  );

  // load return side only sees the read word
  modport load (
    input  ram_rdata
  );

endinterface

//--- lsu/lsu_store_path.sv
// store path: request decode into ram word index, byte write mask and lane-shifted data
`timescale 1ns/1ps

module lsu_store_path (
  input  logic            i_req,
  input  logic            i_wr_en,
  input  lsu_pkg::mem_op_e i_mem_op,
  input  lsu_pkg::addr_t  i_addr,
  input  lsu_pkg::dword_t i_wdata,
  mem_bus_if.store        bus
);
  import lsu_pkg::*;

  // access size as log2 of the byte count
  logic [1:0] size_log2;
  // byte offset after aligning down to the size
  lane_ofs_t  ofs_aligned;
  // mask and data sitting in lane 0 before the shift
  byte_mask_t base_mask;
  dword_t     base_data;
  // a real access this cycle, code 111 is dropped
  logic       access;

  always_comb begin
    size_log2   = op_size_log2(i_mem_op);
    ofs_aligned = align_ofs(i_addr[OFS_W-1:0], size_log2);
  end

  // low-order bytes of the store data, upper bytes zeroed
  always_comb begin
    case (size_log2)
      2'd0: begin
        base_mask = 8'b0000_0001;
        base_data = dword_t'(i_wdata[7:0]);
      end
      2'd1: begin
        base_mask = 8'b0000_0011;
        base_data = dword_t'(i_wdata[15:0]);
      end
      2'd2: begin
        base_mask = 8'b0000_1111;
        base_data = dword_t'(i_wdata[31:0]);
      end
      default: begin
        base_mask = 8'b1111_1111;
        base_data = i_wdata;
      end
    endcase
  end

  assign access = i_req && (i_mem_op != OP_NONE);

  // write or read strobe, one or the other
  assign bus.ram_wen = access && i_wr_en;
  assign bus.ram_ren = access && !i_wr_en;

  // move mask and data up to the addressed lane
  assign bus.ram_wmask = base_mask << ofs_aligned;
  assign bus.ram_wdata = base_data << {ofs_aligned, 3'b000};

  // word index from the bits above the offset
  // upper address bits are ignored so the index wraps
  assign bus.ram_idx = i_addr[OFS_W +: WORD_IDX_W];

endmodule

//--- lsu/lsu_load_path.sv
// load path: pending load tracking, byte lane select and sign or zero extension
`timescale 1ns/1ps

module lsu_load_path (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_req,
  input  logic             i_wr_en,
  input  lsu_pkg::mem_op_e i_mem_op,
  input  lsu_pkg::lane_ofs_t i_ofs,
  mem_bus_if.load          bus,
  output lsu_pkg::dword_t  o_rdata,
  output logic             o_rvalid
);
  import lsu_pkg::*;

  // a load was issued to the ram last cycle
  logic      pend_vld;
  // code and aligned offset of that load
  mem_op_e   pend_op;
  lane_ofs_t pend_ofs;
  // read word moved down so the wanted bytes sit in lane 0
  dword_t    lane_data;
  // extended result before the output register
  dword_t    ext_data;
  // load accepted this cycle
  logic      load_req;

  assign load_req = i_req && !i_wr_en && (i_mem_op != OP_NONE);

  // first stage, sampled together with the ram read strobe
  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      pend_vld <= 1'b0;
    end else begin
      pend_vld <= load_req;
    end
  end

  // payload only, loaded on an accepted load
  always_ff @(posedge i_clk) begin
    if (load_req) begin
      pend_op  <= i_mem_op;
      pend_ofs <= align_ofs(i_ofs, op_size_log2(i_mem_op));
    end
  end

  // ram word is valid this cycle, shift the addressed bytes down
  assign lane_data = bus.ram_rdata >> {pend_ofs, 3'b000};

  always_comb begin
    case (pend_op)
      OP_BYTE_S: ext_data = {{56{lane_data[7]}}, lane_data[7:0]};
      OP_BYTE_U: ext_data = {56'b0, lane_data[7:0]};
      OP_HALF_S: ext_data = {{48{lane_data[15]}}, lane_data[15:0]};
      OP_HALF_U: ext_data = {48'b0, lane_data[15:0]};
      OP_WORD_S: ext_data = {{32{lane_data[31]}}, lane_data[31:0]};
      OP_WORD_U: ext_data = {32'b0, lane_data[31:0]};
      // double, offset is always zero here
      default:   ext_data = lane_data;
    endcase
  end

  // second stage, valid strobe two edges after the request
  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      o_rvalid <= 1'b0;
    end else begin
      o_rvalid <= pend_vld;
    end
  end

  // result holds its value between loads
  always_ff @(posedge i_clk) begin
    if (pend_vld) begin
      o_rdata <= ext_data;
    end
  end

endmodule

//--- mem/data_ram.sv
// data ram: 64-bit wide byte-writable storage array with registered read
`timescale 1ns/1ps

module data_ram (
  input logic    i_clk,
  mem_bus_if.ram bus
);
  import lsu_pkg::*;

  // storage, contents undefined until written
  dword_t mem [MEM_WORDS];

  // byte-masked write at the edge
  // bytes with a clear mask bit keep their old value
  always_ff @(posedge i_clk) begin
    if (bus.ram_wen) begin
      for (int b = 0; b < DWORD_BYTES; b++) begin
        if (bus.ram_wmask[b]) begin
          mem[bus.ram_idx][b*8 +: 8] <= bus.ram_wdata[b*8 +: 8];
        end
      end
    end
  end

  // read word captured at the edge, seen by the load path next cycle
  // a write in an earlier cycle is already visible here
  always_ff @(posedge i_clk) begin
    if (bus.ram_ren) begin
      bus.ram_rdata <= mem[bus.ram_idx];
    end
  end

endmodule

//--- rtl/ls_subsys_top.sv
// load/store subsystem top: store path, data ram and load path on plain ports
`timescale 1ns/1ps

module ls_subsys_top (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_req,
  input  logic        i_wr_en,
  input  logic [2:0]  i_mem_op,
  input  logic [63:0] i_addr,
  input  logic [63:0] i_wdata,
  output logic [63:0] o_rdata,
  output logic        o_rvalid
);
  import lsu_pkg::*;

  // operation code as the enum used inside
  mem_op_e   req_op;
  // low address bits, the byte offset inside a word
  lane_ofs_t req_ofs;

  assign req_op  = mem_op_e'(i_mem_op);
  assign req_ofs = i_addr[OFS_W-1:0];

  // bus between the request decode, the ram and the load return
  mem_bus_if u_bus ();

  // combinational request decode onto the bus
  lsu_store_path u_store_path (
    .i_req    (i_req),
    .i_wr_en  (i_wr_en),
    .i_mem_op (req_op),
    .i_addr   (i_addr),
    .i_wdata  (i_wdata),
    .bus      (u_bus.store)
  );

  data_ram u_data_ram (
    .i_clk (i_clk),
    .bus   (u_bus.ram)
  );

  // load return, two cycles after the request
  lsu_load_path u_load_path (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_req    (i_req),
    .i_wr_en  (i_wr_en),
    .i_mem_op (req_op),
    .i_ofs    (req_ofs),
    .bus      (u_bus.load),
    .o_rdata  (o_rdata),
    .o_rvalid (o_rvalid)
  );

endmodule

//--- verification/ls_ref_model.svh
// testbench memory model: byte-wide ram image, store update and expected load value
`ifndef LS_REF_MODEL_SVH
`define LS_REF_MODEL_SVH

  // ram image, one entry per byte address
  logic [7:0] model_mem [MEM_WORDS*8];

  // access size in bytes, taken from the operation code table
  function automatic int access_bytes(logic [2:0] op);
    case (op)
      3'b000, 3'b001: return 1;
      3'b010, 3'b011: return 2;
      3'b100, 3'b101: return 4;
      default:        return 8;
    endcase
  endfunction

  // first byte of the access
  // address wraps on the ram size, then drops the bits below the access size
  function automatic int first_byte(addr_t addr, logic [2:0] op);
    int a;
    a = int'(addr % 64'(MEM_WORDS * 8));
    return a - (a % access_bytes(op));
  endfunction

  // store writes only the bytes of its own size, from the low end of the data
  function automatic void model_store(addr_t addr, logic [2:0] op, dword_t data);
    int n;
    int b;
    n = access_bytes(op);
    b = first_byte(addr, op);
    for (int i = 0; i < n; i++) begin
      model_mem[b + i] = data[i*8 +: 8];
    end
  endfunction

  // load gathers the bytes little endian, then extends to 64 bits
  function automatic dword_t model_load(addr_t addr, logic [2:0] op);
    int n;
    int b;
    dword_t val;
    logic sign_ext;
    n = access_bytes(op);
    b = first_byte(addr, op);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val[i*8 +: 8] = model_mem[b + i];
    end
    // signed byte, half and word codes
    sign_ext = (op == 3'b000) || (op == 3'b010) || (op == 3'b100);
    if (sign_ext && val[n*8-1]) begin
      for (int k = n * 8; k < 64; k++) begin
        val[k] = 1'b1;
      end
    end
    return val;
  endfunction

`endif

//--- verification/tb_ls_subsys.sv
// testbench for the load/store subsystem: clock, reset, random requests, load checks, report
`timescale 1ns/1ps

module tb_ls_subsys;
  import lsu_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int INIT_STORES  = 256;
  localparam int NUM_REQS     = 2000;
  localparam int DRAIN_CYCLES = 20;
  // each random request may be followed by one idle cycle
  localparam int CYCLE_LIMIT  = RESET_CYCLES + INIT_STORES + 2 * NUM_REQS + DRAIN_CYCLES;

  logic        i_clk = 1'b0;
  logic        i_rst;
  logic        i_req;
  logic        i_wr_en;
  logic [2:0]  i_mem_op;
  logic [63:0] i_addr;
  logic [63:0] i_wdata;
  logic [63:0] o_rdata;
  logic        o_rvalid;

  int seed = 56;
  int cycle = 0;
  int data_errs = 0;
  int hs_errs = 0;
  int loads_done = 0;

  // expected loads in issue order with the value and the cycle of the valid strobe
  dword_t exp_data_q[$];
  int     exp_due_q[$];

  `include "ls_ref_model.svh"

  ls_subsys_top i_dut (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_req    (i_req),
    .i_wr_en  (i_wr_en),
    .i_mem_op (i_mem_op),
    .i_addr   (i_addr),
    .i_wdata  (i_wdata),
    .o_rdata  (o_rdata),
    .o_rvalid (o_rvalid)
  );

  // 40 ns period
  always #20 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle <= cycle + 1;
  end

  // run limit
  always @(posedge i_clk) begin
    if (cycle >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d loads still outstanding", cycle, exp_due_q.size());
      $display("errors: data %0d handshake %0d", data_errs, hs_errs);
      $display("Test failed");
      $finish;
    end
  end

  // drive one request just after the edge and mirror it into the model
  task automatic drive_request(input logic req, input logic wr, input logic [2:0] op,
                               input addr_t addr, input dword_t wdata);
    @(posedge i_clk);
    #2;
    i_req    = req;
    i_wr_en  = wr;
    i_mem_op = op;
    i_addr   = addr;
    i_wdata  = wdata;
    if (req && (op != 3'b111)) begin
      if (wr) begin
        model_store(addr, op, wdata);
      end else begin
        // sampled at the next edge and returned one edge later
        exp_data_q.push_back(model_load(addr, op));
        exp_due_q.push_back(cycle + 2);
      end
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge i_clk) begin : rvalid_check
    dword_t exp;
    int     due;
    if (i_rst) begin
      if (o_rvalid) begin
        assert (exp_due_q.size() != 0) else begin
          $display("%0t: o_rvalid high with no load outstanding", $time);
          hs_errs++;
        end
        if (exp_due_q.size() != 0) begin
          exp = exp_data_q.pop_front();
          due = exp_due_q.pop_front();
          loads_done++;
          assert (due == cycle) else begin
            $display("%0t: o_rvalid in cycle %0d, load was due in cycle %0d", $time, cycle, due);
            hs_errs++;
          end
          assert (o_rdata === exp) else begin
            $display("ERR %0t o_rdata expected %h actual %h", $time, exp, o_rdata);
            data_errs++;
          end
        end
      end else if (exp_due_q.size() != 0) begin
        // a late front load is dropped so later loads stay aligned
        assert (exp_due_q[0] > cycle) else begin
          $display("%0t: missing o_rvalid for load due in cycle %0d", $time, exp_due_q[0]);
          hs_errs++;
          exp = exp_data_q.pop_front();
          due = exp_due_q.pop_front();
        end
      end
    end
  end

  initial begin : stimulus
    logic [31:0] rnd;
    logic [31:0] rnd_addr;
    logic [31:0] rnd_hi;
    logic [31:0] rnd_lo;
    addr_t       addr;
    addr_t       last_addr;
    i_rst    = 1'b0;
    i_req    = 1'b0;
    i_wr_en  = 1'b0;
    i_mem_op = 3'b111;
    i_addr   = '0;
    i_wdata  = '0;
    last_addr = '0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    #2;
    i_rst = 1'b1;

    // fill every ram word so each load has a known value
    for (int w = 0; w < INIT_STORES; w++) begin
      rnd_hi = $random(seed);
      rnd_lo = $random(seed);
      drive_request(1'b1, 1'b1, 3'b110, addr_t'(w * 8), {rnd_hi, rnd_lo});
    end

    for (int r = 0; r < NUM_REQS; r++) begin
      rnd      = $random(seed);
      rnd_addr = $random(seed);
      rnd_hi   = $random(seed);
      rnd_lo   = $random(seed);
      // a quarter of the requests hit the previous word to get a store then a load on one word
      if (rnd[13:12] == 2'd0) begin
        addr = {last_addr[63:3], rnd[2:0]};
      end else begin
        addr = 64'(rnd_addr[10:0]);
      end
      last_addr = addr;
      drive_request(1'b1, rnd[3], rnd[6:4], addr, {rnd_hi, rnd_lo});
      // optional idle cycle while the other inputs keep moving
      if (rnd[7]) begin
        drive_request(1'b0, rnd[8], rnd[11:9], addr, {rnd_lo, rnd_hi});
      end
    end
    drive_request(1'b0, 1'b0, 3'b111, '0, '0);

    // wait for the outstanding loads, then a few quiet cycles
    while (exp_due_q.size() != 0) begin
      @(posedge i_clk);
    end
    repeat (3) @(posedge i_clk);

    $display("errors: data %0d handshake %0d, loads checked %0d", data_errs, hs_errs, loads_done);
    if ((data_errs + hs_errs) == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+verification
common/lsu_pkg.sv
common/mem_bus_if.sv
lsu/lsu_store_path.sv
lsu/lsu_load_path.sv
mem/data_ram.sv
rtl/ls_subsys_top.sv
verification/tb_ls_subsys.sv

//--- run.sh
#!/bin/sh
# compile and run the load/store subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f project.f \
  --top-module tb_ls_subsys \
  -Mdir obj_dir

./obj_dir/Vtb_ls_subsys | tee sim.log

if grep -qx "Test passed" sim.log; then
  echo "simulation result: PASS"
else
  echo "simulation result: FAIL"
  exit 1
fi
